// ==== Bender.yml ====
package:
  name: int_alu

sources:
  - files:
      - hw/int_alu_pkg.sv
      - hw/alu_unit_if.sv
      - hw/alu_issue.sv
      - hw/int_arith_unit.sv
      - hw/int_to_float.sv
      - hw/float_to_int.sv
      - hw/alu_retire.sv
      - hw/int_alu_top.sv
  - target: test
    files:
      - test/tb_int_alu.sv

// ==== hw/alu_issue.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// ALU issue stage
// Registers requests, computes fast results, starts units
////////////////////////////////////////////////////////////

module alu_issue import int_alu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    req,
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    input  logic    busy,
    output logic    fast_valid,
    output word_t   fast_result,
    output logic    fast_except,
    alu_unit_if.issue arith,
    alu_unit_if.issue itof,
    alu_unit_if.issue ftoi
);

    logic      accept;
    unit_sel_t unit;
    word_t     fast_word;
    word_t     a_q;
    word_t     b_q;
    arith_fn_t fn_q;

    // Requests during a slow operation are dropped
    assign accept = req && !busy;
    assign unit = unit_of(op);

    // Logic and halfword results
    always_comb begin
        if (!op[3]) begin
            case (op[1:0])
                2'b00:   fast_word = ~a;
                2'b01:   fast_word = a & b;
                2'b10:   fast_word = a | b;
                default: fast_word = a ^ b;
            endcase
        end else if (!op[0]) begin
            fast_word = {b[15:0], a[15:0]};
        end else begin
            fast_word = {a[31:16], b[15:0]};
        end
    end

    // Strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            fast_valid  <= 1'b0;
            arith.start <= 1'b0;
            itof.start  <= 1'b0;
            ftoi.start  <= 1'b0;
        end else begin
            fast_valid  <= accept && (unit == unit_fast);
            arith.start <= accept && (unit == unit_arith);
            itof.start  <= accept && (unit == unit_itof);
            ftoi.start  <= accept && (unit == unit_ftoi);
        end
    end

    // Payload, held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            fast_result <= fast_word;
            a_q         <= a;
            b_q         <= b;
            fn_q        <= arith_fn_t'(op[1:0]);
        end
    end

    // Logic and halfword ops never raise an exception
    assign fast_except = 1'b0;

    assign arith.a  = a_q;
    assign arith.b  = b_q;
    assign arith.fn = fn_q;
    assign itof.a   = a_q;
    assign itof.b   = b_q;
    assign itof.fn  = fn_q;
    assign ftoi.a   = a_q;
    assign ftoi.b   = b_q;
    assign ftoi.fn  = fn_q;

endmodule

`default_nettype wire

// ==== hw/alu_retire.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// ALU retire stage
// Result select, zero flag, output registers and busy
////////////////////////////////////////////////////////////

module alu_retire import int_alu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fast_valid,
    input  word_t      fast_result,
    input  logic       fast_except,
    alu_unit_if.issue  arith,
    alu_unit_if.issue  itof,
    alu_unit_if.issue  ftoi,
    input  logic       slow_start,
    output word_t      result,
    output alu_flags_t flags,
    output logic       result_valid,
    output logic       busy
);

    logic  sel_valid;
    word_t sel_result;
    logic  sel_except;
    logic  slow_done;
    logic  busy_q;

    assign slow_done = arith.done || itof.done || ftoi.done;

    // At most one strobe is high per cycle
    always_comb begin
        sel_valid  = 1'b1;
        sel_result = fast_result;
        sel_except = fast_except;
        if (arith.done) begin
            sel_result = arith.result;
            sel_except = arith.except;
        end else if (itof.done) begin
            sel_result = itof.result;
            sel_except = itof.except;
        end else if (ftoi.done) begin
            sel_result = ftoi.result;
            sel_except = ftoi.except;
        end else if (!fast_valid) begin
            sel_valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            busy_q       <= 1'b0;
        end else begin
            result_valid <= sel_valid;
            if (slow_done) begin
                busy_q <= 1'b0;
            end else if (slow_start) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            result       <= sel_result;
            flags.except <= sel_except;
            flags.zero   <= (sel_result == '0);
        end
    end

    // High from the unit start until the result retires
    assign busy = busy_q || slow_start;

endmodule

`default_nettype wire

// ==== hw/alu_unit_if.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Start/done link between issue and one multi-cycle unit
////////////////////////////////////////////////////////////

interface alu_unit_if import int_alu_pkg::*; ();

    logic      start;
    word_t     a;
    word_t     b;
    arith_fn_t fn;
    word_t     result;
    logic      except;
    logic      done;

    // Issue side launches work
    modport issue (output start, a, b, fn, input result, except, done);

    // Unit side returns a result with a done strobe
    modport unit (input start, a, b, fn, output result, except, done);

endinterface

`default_nettype wire

// ==== hw/float_to_int.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Single-precision float to integer
// Truncates toward zero, saturates out-of-range values
////////////////////////////////////////////////////////////

module float_to_int import int_alu_pkg::*; (
    input  logic clk,
    input  logic reset,
    alu_unit_if.unit port
);

    // Exponent of 2^31 and above
    localparam logic [7:0] sat_expo = 8'(float_bias + 31);

    logic        sign;
    logic [7:0]  expo;
    logic [22:0] frac;
    logic [31:0] mag;
    word_t       conv;
    logic        invalid;

    always_comb begin
        sign    = port.a[31];
        expo    = port.a[30:23];
        frac    = port.a[22:0];
        mag     = '0;
        conv    = '0;
        invalid = 1'b0;
        // NaN and infinity land here too
        if (expo >= sat_expo) begin
            if (sign && (expo == sat_expo) && (frac == '0)) begin
                conv = word_min;
            end else begin
                invalid = 1'b1;
                conv    = sign ? word_min : word_max;
            end
        end else if (expo >= 8'(float_bias)) begin
            // 1.frac placed at bit 31, then shifted into place
            mag  = {1'b1, frac, 8'b0} >> (sat_expo - expo);
            conv = sign ? -mag : mag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            port.done <= 1'b0;
        end else begin
            port.done <= port.start;
        end
    end

    always_ff @(posedge clk) begin
        if (port.start) begin
            port.result <= conv;
            port.except <= invalid;
        end
    end

endmodule

`default_nettype wire

// ==== hw/int_alu_pkg.sv ====
`default_nettype none
////////////////////////////////////////////////////////////
// Integer ALU shared definitions
// Opcode, data word, flag and unit-select types
////////////////////////////////////////////////////////////

package int_alu_pkg;

    typedef logic signed [31:0] word_t;

    // 00xx arithmetic, 01xx logic, 1xxx special (bit 2 ignored)
    typedef enum logic [3:0] {
        op_add       = 4'b0000,
        op_sub       = 4'b0001,
        op_mul       = 4'b0010,
        op_div       = 4'b0011,
        op_not       = 4'b0100,
        op_and       = 4'b0101,
        op_or        = 4'b0110,
        op_xor       = 4'b0111,
        op_merge_low = 4'b1000,
        op_write_low = 4'b1001,
        op_itof      = 4'b1010,
        op_ftoi      = 4'b1011
    } alu_op_t;

    // Arithmetic unit function, same as opcode low bits
    typedef enum logic [1:0] {
        fn_add = 2'b00,
        fn_sub = 2'b01,
        fn_mul = 2'b10,
        fn_div = 2'b11
    } arith_fn_t;

    typedef struct packed {
        logic except;
        logic zero;
    } alu_flags_t;

    typedef enum logic [1:0] {
        unit_fast,
        unit_arith,
        unit_itof,
        unit_ftoi
    } unit_sel_t;

    localparam word_t word_min = 32'sh8000_0000;
    localparam word_t word_max = 32'sh7fff_ffff;
    localparam int float_bias = 127;

    // Owning unit of an opcode
    function automatic unit_sel_t unit_of(alu_op_t op);
        if (!op[3]) begin
            return op[2] ? unit_fast : unit_arith;
        end
        case (op[1:0])
            2'b10:   return unit_itof;
            2'b11:   return unit_ftoi;
            default: return unit_fast;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hw/int_alu_top.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Integer execute unit
// Issue, execution units and retire in three stages
////////////////////////////////////////////////////////////

module int_alu_top import int_alu_pkg::*; #(
    parameter int mul_div_steps = 32
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  alu_op_t    op,
    input  word_t      a,
    input  word_t      b,
    output word_t      result,
    output alu_flags_t flags,
    output logic       result_valid,
    output logic       busy
);

    logic  fast_valid;
    word_t fast_result;
    logic  fast_except;
    logic  slow_start;

    alu_unit_if arith_bus ();
    alu_unit_if itof_bus ();
    alu_unit_if ftoi_bus ();

    assign slow_start = arith_bus.start | itof_bus.start | ftoi_bus.start;

    alu_issue issue0 (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .a           (a),
        .b           (b),
        .busy        (busy),
        .fast_valid  (fast_valid),
        .fast_result (fast_result),
        .fast_except (fast_except),
        .arith       (arith_bus.issue),
        .itof        (itof_bus.issue),
        .ftoi        (ftoi_bus.issue)
    );

    int_arith_unit #(
        .mul_div_steps (mul_div_steps)
    ) arith0 (
        .clk   (clk),
        .reset (reset),
        .port  (arith_bus.unit)
    );

    int_to_float itof0 (
        .clk   (clk),
        .reset (reset),
        .port  (itof_bus.unit)
    );

    float_to_int ftoi0 (
        .clk   (clk),
        .reset (reset),
        .port  (ftoi_bus.unit)
    );

    alu_retire retire0 (
        .clk          (clk),
        .reset        (reset),
        .fast_valid   (fast_valid),
        .fast_result  (fast_result),
        .fast_except  (fast_except),
        .arith        (arith_bus.issue),
        .itof         (itof_bus.issue),
        .ftoi         (ftoi_bus.issue),
        .slow_start   (slow_start),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid),
        .busy         (busy)
    );

endmodule

`default_nettype wire

// ==== hw/int_arith_unit.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Integer arithmetic unit
// Single-cycle add/sub, iterative multiply and divide
////////////////////////////////////////////////////////////

module int_arith_unit import int_alu_pkg::*; #(
    parameter int mul_div_steps = 32
) (
    input  logic clk,
    input  logic reset,
    alu_unit_if.unit port
);

    localparam int count_w = $clog2(mul_div_steps);

    logic               running;
    logic [count_w-1:0] count_q;
    logic               last_step;
    arith_fn_t          fn_q;
    logic               neg_q;
    logic               dz_q;
    logic               ovf_q;
    logic [32:0]        work_q;
    logic [31:0]        shf_q;
    logic [31:0]        opb_q;
    logic [32:0]        work_nxt;
    logic [31:0]        shf_nxt;
    logic [31:0]        opb_nxt;
    logic [32:0]        rem_shift;
    logic [32:0]        trial;
    logic [31:0]        mag_a;
    logic [31:0]        mag_b;
    word_t              sum;
    logic               sum_ovf;

    assign mag_a = port.a[31] ? -port.a : port.a;
    assign mag_b = port.b[31] ? -port.b : port.b;
    assign last_step = (count_q == count_w'(mul_div_steps - 1));

    ////////////////////////////////////////////////////////////
    // Add / subtract with signed overflow
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (port.fn == fn_sub) begin
            sum     = port.a - port.b;
            sum_ovf = (port.a[31] != port.b[31]) && (sum[31] != port.a[31]);
        end else begin
            sum     = port.a + port.b;
            sum_ovf = (port.a[31] == port.b[31]) && (sum[31] != port.a[31]);
        end
    end

    ////////////////////////////////////////////////////////////
    // One multiply or divide step
    ////////////////////////////////////////////////////////////
    always_comb begin
        rem_shift = {work_q[31:0], shf_q[31]};
        trial     = rem_shift - {1'b0, opb_q};
        if (fn_q == fn_mul) begin
            // Shift-add over magnitudes
            work_nxt = shf_q[0] ? work_q + {1'b0, opb_q} : work_q;
            shf_nxt  = shf_q >> 1;
            opb_nxt  = opb_q << 1;
        end else begin
            // Restoring divide, quotient bits enter from the right
            work_nxt = trial[32] ? rem_shift : trial;
            shf_nxt  = {shf_q[30:0], ~trial[32]};
            opb_nxt  = opb_q;
        end
    end

    // Control
    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            count_q   <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (!running) begin
                if (port.start) begin
                    if (!port.fn[1]) begin
                        port.done <= 1'b1;
                    end else begin
                        running <= 1'b1;
                        count_q <= '0;
                    end
                end
            end else begin
                count_q <= count_q + 1'b1;
                if (last_step) begin
                    running   <= 1'b0;
                    port.done <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (!running) begin
            if (port.start) begin
                fn_q        <= port.fn;
                port.result <= sum;
                port.except <= sum_ovf;
                neg_q       <= port.a[31] ^ port.b[31];
                dz_q        <= (port.b == '0);
                ovf_q       <= (port.a == word_min) && (port.b == -32'sd1);
                work_q      <= '0;
                shf_q       <= (port.fn == fn_mul) ? mag_b : mag_a << (32 - mul_div_steps);
                opb_q       <= (port.fn == fn_mul) ? mag_a : mag_b;
            end
        end else begin
            work_q <= work_nxt;
            shf_q  <= shf_nxt;
            opb_q  <= opb_nxt;
            // Sign fix on the final step
            if (last_step) begin
                if (fn_q == fn_mul) begin
                    port.result <= neg_q ? -work_nxt[31:0] : work_nxt[31:0];
                    port.except <= 1'b0;
                end else if (dz_q) begin
                    port.result <= '1;
                    port.except <= 1'b1;
                end else begin
                    // min / -1 wraps back to min by itself
                    port.result <= neg_q ? -shf_nxt : shf_nxt;
                    port.except <= ovf_q;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/int_to_float.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Integer to single-precision float, truncating
////////////////////////////////////////////////////////////

module int_to_float import int_alu_pkg::*; (
    input  logic clk,
    input  logic reset,
    alu_unit_if.unit port
);

    localparam logic [7:0] min_expo = 8'(float_bias + 31);

    logic        running;
    logic        sign_q;
    logic [30:0] mag_q;
    logic [7:0]  expo_q;
    logic [31:0] mag_in;
    logic        trivial;

    assign mag_in = port.a[31] ? -port.a : port.a;

    // Zero and the most negative number need no normalization
    assign trivial = (port.a == '0) || (port.a == word_min);

    // Control
    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (!running) begin
                if (port.start) begin
                    if (trivial) begin
                        port.done <= 1'b1;
                    end else begin
                        running <= 1'b1;
                    end
                end
            end else if (mag_q[30]) begin
                running   <= 1'b0;
                port.done <= 1'b1;
            end
        end
    end

    // Normalize one bit per cycle
    always_ff @(posedge clk) begin
        if (!running) begin
            if (port.start) begin
                sign_q      <= port.a[31];
                mag_q       <= mag_in[30:0];
                expo_q      <= 8'(float_bias + 30);
                port.except <= 1'b0;
                port.result <= (port.a == '0) ? '0 : {1'b1, min_expo, 23'b0};
            end
        end else if (mag_q[30]) begin
            // Hidden bit dropped, low bits truncated
            port.result <= {sign_q, expo_q, mag_q[29:7]};
        end else begin
            mag_q  <= mag_q << 1;
            expo_q <= expo_q - 8'd1;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/int_alu_pkg.sv
hw/alu_unit_if.sv
hw/alu_issue.sv
hw/int_arith_unit.sv
hw/int_to_float.sv
hw/float_to_int.sv
hw/alu_retire.sv
hw/int_alu_top.sv
test/tb_int_alu.sv

// ==== test/tb_int_alu.sv ====
`default_nettype none
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Testbench for the integer execute unit
// Random and directed operations checked against a model
////////////////////////////////////////////////////////////

module tb_int_alu import int_alu_pkg::*; ();

    localparam int timeout_cycles = 200;

    typedef struct packed {
        alu_op_t    op;
        word_t      a;
        word_t      b;
        word_t      res;
        alu_flags_t flags;
        int         issued;
        int         latency;
    } expect_t;

    logic       clk;
    logic       reset;
    logic       req;
    alu_op_t    op;
    word_t      a;
    word_t      b;
    word_t      result;
    alu_flags_t flags;
    logic       result_valid;
    logic       busy;
    int         cycle = 0;
    expect_t    pending[$];

    alu_op_t fast_ops [6] = '{op_not, op_and, op_or, op_xor, op_merge_low, op_write_low};

    // Fractions, NaN, infinity, range limits, denormal
    word_t float_edges [11] = '{32'h3f00_0000, 32'hbf7f_ffff, 32'h3f80_0000, 32'h7fc0_0000,
                                32'hffc0_0000, 32'h7f80_0000, 32'hff80_0000, 32'h4f00_0000,
                                32'hcf00_0000, 32'hcf00_0001, 32'h0000_0001};

    int_alu_top #(
        .mul_div_steps (32)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .op           (op),
        .a            (a),
        .b            (b),
        .result       (result),
        .flags        (flags),
        .result_valid (result_valid),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic word_t model_alu(input alu_op_t f_op, input word_t x, input word_t y,
                                        output alu_flags_t fl);
        longint      wide;
        word_t       r;
        logic [31:0] mag;
        int          top;
        int          e;
        fl = '0;
        r  = '0;
        case (f_op)
            op_add, op_sub: begin
                wide = (f_op == op_add) ? longint'(x) + longint'(y) : longint'(x) - longint'(y);
                r = word_t'(wide);
                fl.except = (wide > longint'(word_max)) || (wide < longint'(word_min));
            end
            op_mul: r = word_t'(longint'(x) * longint'(y));
            op_div: begin
                if (y == 0) begin
                    r = '1;
                    fl.except = 1'b1;
                end else if (x == word_min && y == -1) begin
                    r = word_min;
                    fl.except = 1'b1;
                end else begin
                    r = x / y;
                end
            end
            op_not:       r = ~x;
            op_and:       r = x & y;
            op_or:        r = x | y;
            op_xor:       r = x ^ y;
            op_merge_low: r = {y[15:0], x[15:0]};
            op_write_low: r = {x[31:16], y[15:0]};
            op_itof: begin
                mag = x[31] ? -x : x;
                if (mag != 0) begin
                    top = 31;
                    while (!mag[top]) top--;
                    // Leading one moved to bit 31 and mantissa truncated below it
                    mag = mag << (31 - top);
                    r = {x[31], 8'(127 + top), mag[30:8]};
                end
            end
            op_ftoi: begin
                e = int'(x[30:23]) - 127;
                if (x[30:23] == 8'hff || e >= 31) begin
                    if (x == 32'hcf00_0000) begin
                        r = word_min;
                    end else begin
                        r = x[31] ? word_min : word_max;
                        fl.except = 1'b1;
                    end
                end else if (e >= 0) begin
                    wide = longint'({1'b1, x[22:0]});
                    wide = (e >= 23) ? wide << (e - 23) : wide >> (23 - e);
                    r = x[31] ? -word_t'(wide) : word_t'(wide);
                end
            end
            default: r = '0;
        endcase
        fl.zero = (r == 0);
        return r;
    endfunction

    // Cycles from the driving edge to result_valid or 0 when it varies
    function automatic int fixed_latency(input alu_op_t f_op);
        if (f_op == op_add || f_op == op_sub) return 3;
        if (f_op[3:2] == 2'b01 || (f_op[3] && !f_op[1])) return 2;
        return 0;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input word_t got, input word_t want, input expect_t e);
        if (got !== want) begin
            stop_on_error($sformatf("FAIL result got %h expected %h (op %h a %h b %h)",
                                    got, want, e.op, e.a, e.b));
        end
    endtask

    task automatic check_flags(input alu_flags_t got, input alu_flags_t want, input expect_t e);
        if (got !== want) begin
            stop_on_error($sformatf("FAIL flags got %h expected %h (op %h a %h b %h)",
                                    got, want, e.op, e.a, e.b));
        end
    endtask

    task automatic check_latency(input int got, input int want, input expect_t e);
        if (got != want) begin
            stop_on_error($sformatf("FAIL latency got %h expected %h (op %h a %h b %h)",
                                    got, want, e.op, e.a, e.b));
        end
    endtask

    task automatic check_busy(input logic got, input logic want);
        if (got !== want) begin
            stop_on_error($sformatf("FAIL busy got %h expected %h", got, want));
        end
    endtask

    always @(negedge clk) begin : compare_results
        expect_t e;
        if (!reset && result_valid) begin
            if (pending.size() == 0) begin
                stop_on_error("Unexpected result: result_valid with no request outstanding");
            end else begin
                e = pending.pop_front();
                check_result(result, e.res, e);
                check_flags(flags, e.flags, e);
                if (e.latency != 0) check_latency(cycle - e.issued, e.latency, e);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    task automatic send_op(input alu_op_t s_op, input word_t x, input word_t y);
        expect_t    e;
        alu_flags_t fl;
        int         waited;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            req = 1'b0;
            waited++;
            if (waited > timeout_cycles) begin
                stop_on_error("Timeout: result_valid never came, busy stayed high");
            end
            @(negedge clk);
        end
        req = 1'b1;
        op  = s_op;
        a   = x;
        b   = y;
        e.op      = s_op;
        e.a       = x;
        e.b       = y;
        e.res     = model_alu(s_op, x, y, fl);
        e.flags   = fl;
        e.issued  = cycle;
        e.latency = fixed_latency(s_op);
        pending.push_back(e);
    endtask

    task automatic idle();
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0) begin
            waited++;
            if (waited > timeout_cycles) begin
                stop_on_error("Timeout: result_valid never came for an outstanding request");
            end
            @(negedge clk);
        end
        // A stray result would show up here
        repeat (5) @(negedge clk);
    endtask

    // Requests held high during a slow op must be dropped
    task automatic busy_blocks_req();
        int waited;
        waited = 0;
        send_op(op_mul, 32'sd1234, -32'sd77);
        @(negedge clk);
        op = op_xor;
        a  = 32'h5a5a_5a5a;
        b  = 32'h0f0f_0f0f;
        while (!result_valid) begin
            check_busy(busy, 1'b1);
            waited++;
            if (waited > timeout_cycles) begin
                stop_on_error("Timeout: result_valid never came for the multiply");
            end
            @(negedge clk);
        end
        req = 1'b0;
        check_busy(busy, 1'b0);
    endtask

    initial begin
        word_t x;
        word_t y;
        void'($urandom(32'h8df2_adf6));
        reset = 1'b1;
        req   = 1'b0;
        op    = op_add;
        a     = '0;
        b     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Fast ops back to back
        for (int i = 0; i < 60; i++) send_op(fast_ops[$urandom % 6], $urandom, $urandom);
        idle();
        drain();

        // Add and sub with overflow edges
        for (int i = 0; i < 30; i++) send_op(($urandom % 2) ? op_sub : op_add, $urandom, $urandom);
        send_op(op_add, word_max, 32'sd1);
        send_op(op_add, word_min, -32'sd1);
        send_op(op_sub, word_min, 32'sd1);
        send_op(op_sub, word_max, -32'sd1);
        send_op(op_sub, 32'sd0, word_min);
        send_op(op_add, word_min, word_min);
        idle();
        drain();

        // Multiply and divide
        for (int i = 0; i < 30; i++) begin
            x = $urandom;
            y = $urandom;
            y = y >>> ($urandom % 31);
            send_op(($urandom % 2) ? op_mul : op_div, x, y);
        end
        send_op(op_div, 32'sd1234, 32'sd0);
        send_op(op_div, 32'sd0, 32'sd0);
        send_op(op_div, word_min, -32'sd1);
        send_op(op_div, -32'sd7, 32'sd2);
        send_op(op_mul, word_min, -32'sd1);
        idle();
        drain();

        // Conversions
        for (int i = 0; i < 20; i++) begin
            x = $urandom;
            send_op(op_itof, x >>> ($urandom % 32), 32'sd0);
        end
        send_op(op_itof, 32'sd0, 32'sd0);
        send_op(op_itof, word_min, 32'sd0);
        send_op(op_itof, -32'sd1, 32'sd0);
        for (int i = 0; i < 30; i++) begin
            x = $urandom;
            x[30:23] = 8'(110 + $urandom % 56);
            send_op(op_ftoi, x, 32'sd0);
        end
        for (int i = 0; i < 11; i++) send_op(op_ftoi, float_edges[i], 32'sd0);
        idle();
        drain();

        busy_blocks_req();
        drain();

        // Zero results
        x = $urandom;
        send_op(op_xor, x, x);
        send_op(op_sub, 32'sd5, 32'sd5);
        send_op(op_mul, 32'sd0, x);
        send_op(op_ftoi, 32'h3e80_0000, 32'sd0);
        idle();
        drain();

        // Mixed traffic over all opcodes
        for (int i = 0; i < 200; i++) send_op(alu_op_t'($urandom % 12), $urandom, $urandom);
        idle();
        drain();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
